/* Makefile */
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal
EXTRA     ?=

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST))) sim/lsu_ref.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+sim
logic/lsu_pkg.sv
logic/ls_align.sv
logic/lsu_ctrl.sv
logic/lsu_regs.sv
logic/data_ram.sv
logic/lsu_top.sv
sim/lsu_tb.sv

/* logic/data_ram.sv */
`timescale 1ns/100ps

module data_ram (
  input  logic                        clk,
  input  logic                        ram_en,
  input  logic [lsu_pkg::MASK_W-1:0]  ram_be,
  input  logic [lsu_pkg::WADDR_W-1:0] ram_addr,
  input  logic [lsu_pkg::XLEN-1:0]    ram_wdata,
  output logic [lsu_pkg::XLEN-1:0]    ram_rdata
);

  logic [lsu_pkg::XLEN-1:0] mem [lsu_pkg::WORDS];

  // Byte lanes written independently
  always_ff @(posedge clk) begin
    if (ram_en) begin
      for (int i = 0; i < lsu_pkg::MASK_W; i++) begin
        if (ram_be[i])
          mem[ram_addr][8*i +: 8] <= ram_wdata[8*i +: 8];
      end
    end
  end

  // Registered read, one cycle latency
  always_ff @(posedge clk) begin
    if (ram_en && ram_be == '0)
      ram_rdata <= mem[ram_addr];
  end

endmodule

/* logic/ls_align.sv */
`timescale 1ns/100ps

module ls_align (
  input  logic [2:0]                 st_funct3,
  input  logic [1:0]                 st_offset,
  input  logic [lsu_pkg::XLEN-1:0]   st_data,
  output logic [lsu_pkg::XLEN-1:0]   st_lanes,
  output logic [lsu_pkg::MASK_W-1:0] st_mask,
  input  logic [2:0]                 ld_funct3,
  input  logic [1:0]                 ld_offset,
  input  logic [lsu_pkg::XLEN-1:0]   ld_word,
  output logic [lsu_pkg::XLEN-1:0]   ld_data
);

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  // Store side
  always_comb begin
    st_lanes = st_data;
    st_mask  = '0;  // Illegal codes write nothing
    case (st_funct3)
      lsu_pkg::F3_LB: begin
        case (st_offset)
          2'b00: begin
            st_lanes = {24'h0, st_data[7:0]};
            st_mask  = 4'b0001;
          end
          2'b01: begin
            st_lanes = {16'h0, st_data[7:0], 8'h0};
            st_mask  = 4'b0010;
          end
          2'b10: begin
            st_lanes = {8'h0, st_data[7:0], 16'h0};
            st_mask  = 4'b0100;
          end
          default: begin
            st_lanes = {st_data[7:0], 24'h0};
            st_mask  = 4'b1000;
          end
        endcase
      end
      lsu_pkg::F3_LH: begin
        if (st_offset[1]) begin
          st_lanes = {st_data[15:0], 16'h0};
          st_mask  = 4'b1100;
        end else begin
          st_lanes = {16'h0, st_data[15:0]};
          st_mask  = 4'b0011;
        end
      end
      lsu_pkg::F3_LW: begin
        st_lanes = st_data;
        st_mask  = 4'b1111;
      end
      default: ;
    endcase
  end

  // Load side, lane select first
  always_comb begin
    case (ld_offset)
      2'b00:   ld_byte = ld_word[7:0];
      2'b01:   ld_byte = ld_word[15:8];
      2'b10:   ld_byte = ld_word[23:16];
      default: ld_byte = ld_word[31:24];
    endcase
    ld_half = ld_offset[1] ? ld_word[31:16] : ld_word[15:0];
  end

  always_comb begin
    case (ld_funct3)
      lsu_pkg::F3_LB:  ld_data = {{24{ld_byte[7]}}, ld_byte};
      lsu_pkg::F3_LH:  ld_data = {{16{ld_half[15]}}, ld_half};
      lsu_pkg::F3_LW:  ld_data = ld_word;
      lsu_pkg::F3_LBU: ld_data = {24'h0, ld_byte};
      lsu_pkg::F3_LHU: ld_data = {16'h0, ld_half};
      default:         ld_data = '0;
    endcase
  end

endmodule

/* logic/lsu_ctrl.sv */
`timescale 1ns/100ps

module lsu_ctrl (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        req,
  input  logic                        req_we,
  input  logic [2:0]                  req_funct3,
  input  logic [lsu_pkg::ADDR_W-1:0]  req_addr,
  input  logic [lsu_pkg::XLEN-1:0]    req_wdata,
  input  logic [lsu_pkg::XLEN-1:0]    st_lanes,
  input  logic [lsu_pkg::MASK_W-1:0]  st_mask,
  input  logic [lsu_pkg::XLEN-1:0]    ld_data,
  input  logic                        wprot,
  output logic [2:0]                  st_funct3,
  output logic [1:0]                  st_offset,
  output logic [lsu_pkg::XLEN-1:0]    st_data,
  output logic                        ram_en,
  output logic [lsu_pkg::MASK_W-1:0]  ram_be,
  output logic [lsu_pkg::WADDR_W-1:0] ram_addr,
  output logic [lsu_pkg::XLEN-1:0]    ram_wdata,
  output logic [2:0]                  ld_funct3,
  output logic [1:0]                  ld_offset,
  output logic                        rsp_valid,
  output logic                        rsp_fault,
  output logic                        rsp_denied,
  output logic [lsu_pkg::XLEN-1:0]    rsp_rdata,
  output logic                        fault_pulse,
  output logic [lsu_pkg::ADDR_W-1:0]  fault_addr
);

  logic illegal;
  logic misaligned;
  logic fault;
  logic denied;
  logic accept;
  logic load_q;

  assign st_funct3 = req_funct3;
  assign st_offset = req_addr[1:0];
  assign st_data   = req_wdata;

  always_comb begin
    case (req_funct3)
      lsu_pkg::F3_LB, lsu_pkg::F3_LH, lsu_pkg::F3_LW: illegal = 1'b0;
      lsu_pkg::F3_LBU, lsu_pkg::F3_LHU:               illegal = req_we;  // No unsigned stores
      default:                                        illegal = 1'b1;
    endcase
    case (req_funct3[1:0])
      2'b01:   misaligned = req_addr[0];
      2'b10:   misaligned = |req_addr[1:0];
      default: misaligned = 1'b0;
    endcase
  end

  assign fault  = req && (illegal || misaligned);
  assign denied = req && req_we && !fault && wprot;
  assign accept = req && !fault && !denied;

  assign ram_en    = accept;
  assign ram_be    = (accept && req_we) ? st_mask : '0;
  assign ram_addr  = req_addr[lsu_pkg::ADDR_W-1:2];
  assign ram_wdata = st_lanes;

  assign fault_pulse = fault;
  assign fault_addr  = req_addr;

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid  <= 1'b0;
      rsp_fault  <= 1'b0;
      rsp_denied <= 1'b0;
      load_q     <= 1'b0;
    end else begin
      rsp_valid  <= req;
      rsp_fault  <= fault;
      rsp_denied <= denied;
      load_q     <= accept && !req_we;
    end
  end

  // Lane info for the load side, one cycle behind the request
  always_ff @(posedge clk) begin
    ld_funct3 <= req_funct3;
    ld_offset <= req_addr[1:0];
  end

  assign rsp_rdata = load_q ? ld_data : '0;

  assert property (@(posedge clk) disable iff (reset)
    (ram_be != '0) |-> req && req_we && !wprot)
    else $error("lsu_ctrl: RAM write without an accepted store");

  // A legal store always gets at least one lane from the aligner
  assert property (@(posedge clk) disable iff (reset)
    accept && req_we |-> st_mask != '0)
    else $error("lsu_ctrl: empty mask for store code %0h", req_funct3);

  assert property (@(posedge clk) disable iff (reset) req |=> rsp_valid)
    else $error("lsu_ctrl: missing response");

  assert property (@(posedge clk) disable iff (reset) rsp_valid |-> $past(req))
    else $error("lsu_ctrl: response without request");

endmodule

/* logic/lsu_pkg.sv */
package lsu_pkg;

  localparam int XLEN     = 32;
  localparam int ADDR_W   = 12;
  localparam int WORDS    = 1024;
  localparam int WADDR_W  = $clog2(WORDS);  // Word address into data_ram
  localparam int MASK_W   = 4;
  localparam int FCOUNT_W = 16;

  // Load codes; the first three double as SB, SH, SW on stores
  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;

  localparam logic [1:0] REG_CTRL   = 2'd0;  // Bit 0 is write protect
  localparam logic [1:0] REG_FCOUNT = 2'd1;  // Saturating fault count
  localparam logic [1:0] REG_FADDR  = 2'd2;  // Last fault address

endpackage

/* logic/lsu_regs.sv */
`timescale 1ns/100ps

module lsu_regs (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       cfg_we,
  input  logic [1:0]                 cfg_addr,
  input  logic [lsu_pkg::XLEN-1:0]   cfg_wdata,
  input  logic                       fault_pulse,
  input  logic [lsu_pkg::ADDR_W-1:0] fault_addr,
  output logic [lsu_pkg::XLEN-1:0]   cfg_rdata,
  output logic                       wprot
);

  logic [lsu_pkg::FCOUNT_W-1:0] fcount;
  logic [lsu_pkg::ADDR_W-1:0]   faddr;

  always_ff @(posedge clk) begin
    if (reset) begin
      wprot  <= 1'b0;
      fcount <= '0;
      faddr  <= '0;
    end else begin
      if (cfg_we && cfg_addr == lsu_pkg::REG_CTRL)
        wprot <= cfg_wdata[0];
      // Clear wins over a fault in the same cycle
      if (cfg_we && cfg_addr == lsu_pkg::REG_FCOUNT)
        fcount <= '0;
      else if (fault_pulse && fcount != '1)
        fcount <= fcount + 1'b1;
      if (fault_pulse)
        faddr <= fault_addr;
    end
  end

  always_comb begin
    case (cfg_addr)
      lsu_pkg::REG_CTRL:   cfg_rdata = {{(lsu_pkg::XLEN-1){1'b0}}, wprot};
      lsu_pkg::REG_FCOUNT: cfg_rdata = {{(lsu_pkg::XLEN-lsu_pkg::FCOUNT_W){1'b0}}, fcount};
      lsu_pkg::REG_FADDR:  cfg_rdata = {{(lsu_pkg::XLEN-lsu_pkg::ADDR_W){1'b0}}, faddr};
      default:             cfg_rdata = '0;  // Unmapped
    endcase
  end

endmodule

/* logic/lsu_top.sv */
`timescale 1ns/100ps

module lsu_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req,
  input  logic                       req_we,
  input  logic [2:0]                 req_funct3,
  input  logic [lsu_pkg::ADDR_W-1:0] req_addr,
  input  logic [lsu_pkg::XLEN-1:0]   req_wdata,
  output logic                       rsp_valid,
  output logic                       rsp_fault,
  output logic                       rsp_denied,
  output logic [lsu_pkg::XLEN-1:0]   rsp_rdata,
  input  logic                       cfg_we,
  input  logic [1:0]                 cfg_addr,
  input  logic [lsu_pkg::XLEN-1:0]   cfg_wdata,
  output logic [lsu_pkg::XLEN-1:0]   cfg_rdata
);

  logic [2:0]                  st_funct3;
  logic [1:0]                  st_offset;
  logic [lsu_pkg::XLEN-1:0]    st_data;
  logic [lsu_pkg::XLEN-1:0]    st_lanes;
  logic [lsu_pkg::MASK_W-1:0]  st_mask;
  logic [2:0]                  ld_funct3;
  logic [1:0]                  ld_offset;
  logic [lsu_pkg::XLEN-1:0]    ld_data;
  logic                        ram_en;
  logic [lsu_pkg::MASK_W-1:0]  ram_be;
  logic [lsu_pkg::WADDR_W-1:0] ram_addr;
  logic [lsu_pkg::XLEN-1:0]    ram_wdata;
  logic [lsu_pkg::XLEN-1:0]    ram_rdata;
  logic                        wprot;
  logic                        fault_pulse;
  logic [lsu_pkg::ADDR_W-1:0]  fault_addr;

  lsu_ctrl ctrl0 (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .req_we     (req_we),
    .req_funct3 (req_funct3),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .st_lanes   (st_lanes),
    .st_mask    (st_mask),
    .ld_data    (ld_data),
    .wprot      (wprot),
    .st_funct3  (st_funct3),
    .st_offset  (st_offset),
    .st_data    (st_data),
    .ram_en     (ram_en),
    .ram_be     (ram_be),
    .ram_addr   (ram_addr),
    .ram_wdata  (ram_wdata),
    .ld_funct3  (ld_funct3),
    .ld_offset  (ld_offset),
    .rsp_valid  (rsp_valid),
    .rsp_fault  (rsp_fault),
    .rsp_denied (rsp_denied),
    .rsp_rdata  (rsp_rdata),
    .fault_pulse(fault_pulse),
    .fault_addr (fault_addr)
  );

  ls_align align0 (
    .st_funct3(st_funct3),
    .st_offset(st_offset),
    .st_data  (st_data),
    .st_lanes (st_lanes),
    .st_mask  (st_mask),
    .ld_funct3(ld_funct3),
    .ld_offset(ld_offset),
    .ld_word  (ram_rdata),
    .ld_data  (ld_data)
  );

  data_ram ram0 (
    .clk      (clk),
    .ram_en   (ram_en),
    .ram_be   (ram_be),
    .ram_addr (ram_addr),
    .ram_wdata(ram_wdata),
    .ram_rdata(ram_rdata)
  );

  lsu_regs regs0 (
    .clk        (clk),
    .reset      (reset),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .fault_pulse(fault_pulse),
    .fault_addr (fault_addr),
    .cfg_rdata  (cfg_rdata),
    .wprot      (wprot)
  );

endmodule

/* sim/lsu_ref.svh */
`ifndef LSU_REF_SVH
`define LSU_REF_SVH

// Expected RAM image, written as each accepted store is issued
logic [lsu_pkg::XLEN-1:0] shadow [lsu_pkg::WORDS];

function automatic logic is_fault(input logic we, input logic [2:0] f3,
                                  input logic [lsu_pkg::ADDR_W-1:0] addr);
  logic bad_code;
  logic bad_align;
  // Stores only know SB, SH, SW; loads reject 011, 110, 111
  bad_code  = we ? (f3 > lsu_pkg::F3_LW) : (f3 == 3'b011 || f3 > lsu_pkg::F3_LHU);
  bad_align = ((f3 == lsu_pkg::F3_LH || f3 == lsu_pkg::F3_LHU) && addr[0]) ||
              (f3 == lsu_pkg::F3_LW && addr[1:0] != 2'b00);
  return bad_code || bad_align;
endfunction

function automatic logic [lsu_pkg::XLEN-1:0] ref_load(input logic [2:0] f3,
                                                     input logic [lsu_pkg::ADDR_W-1:0] addr);
  logic [lsu_pkg::XLEN-1:0] word;
  logic [lsu_pkg::XLEN-1:0] raw;
  word = shadow[addr[lsu_pkg::ADDR_W-1:2]];
  raw  = word >> (8 * addr[1:0]);  // Addressed byte now at the bottom
  case (f3)
    lsu_pkg::F3_LB:  return {{24{raw[7]}}, raw[7:0]};
    lsu_pkg::F3_LH:  return {{16{raw[15]}}, raw[15:0]};
    lsu_pkg::F3_LBU: return {24'h0, raw[7:0]};
    lsu_pkg::F3_LHU: return {16'h0, raw[15:0]};
    default:         return word;
  endcase
endfunction

function automatic void ref_store(input logic [2:0] f3, input logic [lsu_pkg::ADDR_W-1:0] addr,
                                  input logic [lsu_pkg::XLEN-1:0] data);
  int nbytes;
  int lane;
  nbytes = 1 << f3[1:0];
  for (int i = 0; i < nbytes; i++) begin
    lane = addr[1:0] + i;
    shadow[addr[lsu_pkg::ADDR_W-1:2]][8*lane +: 8] = data[8*i +: 8];
  end
endfunction

`endif

/* sim/lsu_tb.sv */
`timescale 1ns/100ps

module lsu_tb;

  logic                       clk;
  logic                       reset;
  logic                       req;
  logic                       req_we;
  logic [2:0]                 req_funct3;
  logic [lsu_pkg::ADDR_W-1:0] req_addr;
  logic [lsu_pkg::XLEN-1:0]   req_wdata;
  logic                       rsp_valid;
  logic                       rsp_fault;
  logic                       rsp_denied;
  logic [lsu_pkg::XLEN-1:0]   rsp_rdata;
  logic                       cfg_we;
  logic [1:0]                 cfg_addr;
  logic [lsu_pkg::XLEN-1:0]   cfg_wdata;
  logic [lsu_pkg::XLEN-1:0]   cfg_rdata;

  typedef struct packed {
    logic [31:0]              due;  // Cycle in which rsp_valid is expected
    logic                     fault;
    logic                     denied;
    logic [lsu_pkg::XLEN-1:0] rdata;
  } rsp_t;

  rsp_t                         rsp_q [$];
  int                           cycle = 0;
  integer                       seed = 74;
  logic                         model_wprot;
  logic [lsu_pkg::FCOUNT_W-1:0] model_fcount;
  logic [lsu_pkg::ADDR_W-1:0]   model_faddr;

  `include "lsu_ref.svh"

  lsu_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic stop_on_error(input string what);
    $display("test failed");
    $display("%s", what);
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_data(input string name, input logic [lsu_pkg::XLEN-1:0] got,
                            input logic [lsu_pkg::XLEN-1:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_reg(input logic [1:0] addr, input logic [lsu_pkg::XLEN-1:0] got,
                           input logic [lsu_pkg::XLEN-1:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("FAILED cfg_rdata (cfg_addr %h) got %h expected %h",
                              addr, got, exp));
  endtask

  function automatic logic [lsu_pkg::XLEN-1:0] reg_expect(input logic [1:0] addr);
    case (addr)
      lsu_pkg::REG_CTRL:   return {31'h0, model_wprot};
      lsu_pkg::REG_FCOUNT: return {16'h0, model_fcount};
      lsu_pkg::REG_FADDR:  return {20'h0, model_faddr};
      default:             return '0;
    endcase
  endfunction

  // Response checker, mid-cycle where outputs are settled
  always @(negedge clk) begin : response_check
    rsp_t exp;
    if (!reset) begin
      if (rsp_q.size() != 0 && rsp_q[0].due == cycle) begin
        exp = rsp_q.pop_front();
        check_flag("rsp_valid", rsp_valid, 1'b1);
        check_flag("rsp_fault", rsp_fault, exp.fault);
        check_flag("rsp_denied", rsp_denied, exp.denied);
        check_data("rsp_rdata", rsp_rdata, exp.rdata);
      end else begin
        check_flag("rsp_valid", rsp_valid, 1'b0);
      end
    end
  end

  task automatic next_cycle;
    @(posedge clk);
    #1;
  endtask

  task automatic idle;
    req    = 1'b0;
    cfg_we = 1'b0;
    next_cycle();
  endtask

  task automatic issue(input logic we, input logic [2:0] f3,
                       input logic [lsu_pkg::ADDR_W-1:0] addr,
                       input logic [lsu_pkg::XLEN-1:0] data);
    rsp_t exp;
    exp.due    = cycle + 1;
    exp.fault  = is_fault(we, f3, addr);
    exp.denied = we && !exp.fault && model_wprot;
    exp.rdata  = '0;
    if (exp.fault) begin
      if (model_fcount != '1)
        model_fcount = model_fcount + 16'd1;  // Saturates
      model_faddr = addr;
    end else if (!exp.denied) begin
      if (we)
        ref_store(f3, addr, data);
      else
        exp.rdata = ref_load(f3, addr);
    end
    rsp_q.push_back(exp);
    req        = 1'b1;
    req_we     = we;
    req_funct3 = f3;
    req_addr   = addr;
    req_wdata  = data;
    cfg_we     = 1'b0;
    next_cycle();
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [lsu_pkg::XLEN-1:0] data);
    if (addr == lsu_pkg::REG_CTRL)
      model_wprot = data[0];
    else if (addr == lsu_pkg::REG_FCOUNT)
      model_fcount = '0;  // Any data clears
    req       = 1'b0;
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    next_cycle();
    cfg_we = 1'b0;
  endtask

  task automatic read_reg(input logic [1:0] addr);
    req      = 1'b0;
    cfg_we   = 1'b0;
    cfg_addr = addr;
    @(negedge clk);
    check_reg(addr, cfg_rdata, reg_expect(addr));
    next_cycle();
  endtask

  // Every load form around one word, plus both neighbours
  task automatic load_all_forms(input logic [lsu_pkg::ADDR_W-1:0] base);
    issue(1'b0, lsu_pkg::F3_LW, base - 4, '0);
    issue(1'b0, lsu_pkg::F3_LW, base, '0);
    issue(1'b0, lsu_pkg::F3_LW, base + 4, '0);
    for (int o = 0; o < 4; o++) begin
      issue(1'b0, lsu_pkg::F3_LB, base + o, '0);
      issue(1'b0, lsu_pkg::F3_LBU, base + o, '0);
    end
    for (int o = 0; o < 4; o += 2) begin
      issue(1'b0, lsu_pkg::F3_LH, base + o, '0);
      issue(1'b0, lsu_pkg::F3_LHU, base + o, '0);
    end
  endtask

  task automatic drain;
    int waited;
    waited = 0;
    while (rsp_q.size() != 0 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
  endtask

  initial begin : watchdog
    for (int n = 0; n < 20000; n++)
      @(posedge clk);
    $display("test failed");
    $display("Simulation did not finish within 20000 cycles");
    $fatal(1);
  end

  initial begin : stimulus
    logic [31:0]                rnd;
    logic [lsu_pkg::ADDR_W-1:0] a;
    reset = 1'b1;
    req = 1'b0;
    req_we = 1'b0;
    req_funct3 = '0;
    req_addr = '0;
    req_wdata = '0;
    cfg_we = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    model_wprot = 1'b0;
    model_fcount = '0;
    model_faddr = '0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int r = 0; r < 3; r++)
      read_reg(r);

    // Fill all words, then read them back to back
    for (int w = 0; w < lsu_pkg::WORDS; w++)
      issue(1'b1, lsu_pkg::F3_LW, w * 4, $random(seed));
    for (int w = 0; w < lsu_pkg::WORDS; w++)
      issue(1'b0, lsu_pkg::F3_LW, w * 4, '0);

    // Sub-word stores at every legal offset
    for (int b = 0; b < 4; b++) begin
      a = 12'h200 + b * 16;
      for (int o = 0; o < 4; o++)
        issue(1'b1, lsu_pkg::F3_LB, a + o, $random(seed));
      load_all_forms(a);
      issue(1'b1, lsu_pkg::F3_LH, a, $random(seed));
      issue(1'b1, lsu_pkg::F3_LH, a + 2, $random(seed));
      load_all_forms(a);
    end

    // Every code, direction and offset; faults counted
    write_reg(lsu_pkg::REG_FCOUNT, '0);
    for (int we = 0; we < 2; we++)
      for (int f = 0; f < 8; f++)
        for (int o = 0; o < 4; o++)
          issue(we[0], f[2:0], 12'h300 + o, $random(seed));
    load_all_forms(12'h300);
    read_reg(lsu_pkg::REG_FCOUNT);
    read_reg(lsu_pkg::REG_FADDR);

    // Write protection
    write_reg(lsu_pkg::REG_CTRL, 32'h1);
    read_reg(lsu_pkg::REG_CTRL);
    for (int o = 0; o < 3; o++)
      issue(1'b1, lsu_pkg::F3_LW, 12'h400 + o * 4, $random(seed));
    issue(1'b1, lsu_pkg::F3_LB, 12'h405, $random(seed));
    issue(1'b1, lsu_pkg::F3_LH, 12'h406, $random(seed));
    read_reg(lsu_pkg::REG_FCOUNT);
    issue(1'b1, lsu_pkg::F3_LW, 12'h409, $random(seed));  // Fault beats denial
    load_all_forms(12'h404);
    read_reg(lsu_pkg::REG_FCOUNT);
    read_reg(lsu_pkg::REG_FADDR);
    write_reg(lsu_pkg::REG_CTRL, 32'h0);

    // Count clear and unmapped address
    write_reg(lsu_pkg::REG_FCOUNT, 32'hdeadbeef);
    read_reg(lsu_pkg::REG_FCOUNT);
    write_reg(2'd3, 32'hffffffff);
    read_reg(2'd3);
    read_reg(lsu_pkg::REG_CTRL);

    // Random mix
    for (int n = 0; n < 3000; n++) begin
      rnd = $random(seed);
      if (rnd[31:28] == 4'd0) begin
        write_reg(lsu_pkg::REG_CTRL, {31'h0, rnd[0]});
      end else if (rnd[31:28] == 4'd1) begin
        read_reg(rnd[1:0]);
      end else if (rnd[31:28] == 4'd2) begin
        idle();
      end else if (rnd[31:24] == 8'h30) begin
        write_reg(lsu_pkg::REG_FCOUNT, '0);
      end else begin
        a = rnd[15:4];
        if (rnd[16])
          a[1:0] = 2'b00;  // Bias toward aligned
        issue(rnd[0], rnd[3:1], a, $random(seed));
      end
    end
    read_reg(lsu_pkg::REG_FCOUNT);
    read_reg(lsu_pkg::REG_FADDR);

    idle();
    drain();
    if (rsp_q.size() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $display("Responses still pending after the drain timeout");
      $fatal(1);
    end
  end

endmodule
